// ==== common/blit_inner_pkg.sv ====
// Blitter inner loop package with phase and read-kind types, command layout and count width
package blit_inner_pkg;

	// Inner loop memory phases in pipeline order
	// X phases only run on the first pixel of a loop
	typedef enum logic [3:0] {
		IDLE,
		SREADX,
		SZREADX,
		SREAD,
		SZREAD,
		DREAD,
		DZREAD,
		DWRITE,
		DZWRITE
	} inner_phase_e;

	// Kind of the single outstanding read
	// Extra source reads share the plain source kinds
	typedef enum logic [2:0] {
		RD_NONE,
		RD_SRC,
		RD_SRC_Z,
		RD_DST,
		RD_DST_Z
	} read_kind_e;

	// Width of the command word
	localparam int CMD_W = 6;

	// Bit positions of the phase enables in the command word
	localparam int CMD_SRC_EN = 0;
	localparam int CMD_SRC_Z_EN = 1;
	localparam int CMD_SRC_X_EN = 2;
	localparam int CMD_DST_EN = 3;
	localparam int CMD_DST_Z_EN = 4;
	// Adds a Z write after each destination write
	localparam int CMD_DST_WR_Z = 5;

	// Default pixel count width
	localparam int DEF_COUNT_W = 16;

endpackage

// ==== inner_seq/inner_cmd_reg.sv ====
// Inner loop command register, holds the command word and splits out the phase enables
module inner_cmd_reg
	import blit_inner_pkg::*;
(
	input  logic             sys_clk,
	input  logic             resetl,
	input  logic             cmd_ld,
	input  logic [CMD_W-1:0] cmd_data,
	output logic             src_en,
	output logic             src_z_en,
	output logic             src_x_en,
	output logic             dst_en,
	output logic             dst_z_en,
	output logic             dst_wr_z
);

	// Registered command word
	logic [CMD_W-1:0] cmd_q;

	// Load on cmd_ld, enables visible the cycle after
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			cmd_q <= '0;
		end else if (cmd_ld) begin
			cmd_q <= cmd_data;
		end
	end

	// Source phase enables
	assign src_en = cmd_q[CMD_SRC_EN];
	assign src_z_en = cmd_q[CMD_SRC_Z_EN];
	// Extra source read, first pixel only
	assign src_x_en = cmd_q[CMD_SRC_X_EN];

	// Destination phase enables
	assign dst_en = cmd_q[CMD_DST_EN];
	assign dst_z_en = cmd_q[CMD_DST_Z_EN];
	assign dst_wr_z = cmd_q[CMD_DST_WR_Z];

endmodule

// ==== inner_seq/inner_sequencer.sv ====
// Inner loop sequencer that steps the pixel phases and issues the memory requests
module inner_sequencer
	import blit_inner_pkg::*;
(
	input  logic         sys_clk,
	input  logic         resetl,
	input  logic         inner_start,
	input  logic         mem_ready,
	input  logic         no_write,
	input  logic         read_wait,
	input  logic         last_pixel,
	input  logic         src_en,
	input  logic         src_z_en,
	input  logic         src_x_en,
	input  logic         dst_en,
	input  logic         dst_z_en,
	input  logic         dst_wr_z,
	output inner_phase_e phase,
	output logic         step,
	output logic         read_req,
	output logic         write_req,
	output logic         z_addr,
	output logic         inner_done
);

	// Startup latch and its next value
	logic stup_q;
	logic stup_d;
	// Start seen now or held from an earlier cycle
	logic startup;

	// Phase chosen by the next step
	inner_phase_e nxt_phase;
	// First destination phase of a pixel
	inner_phase_e dst_start;
	// First phase of a pixel after the X phases
	inner_phase_e pix_start;

	// Last pixel flag taken at the destination write for the Z write
	logic last_q;

	logic is_read;
	logic is_write;
	logic loop_end;

	// Start is only taken while idle and held until the first step
	assign startup = inner_start | stup_q;
	assign stup_d = (stup_q | (inner_start & (phase == IDLE))) & ~step;

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			stup_q <= 1'b0;
		end else begin
			stup_q <= stup_d;
		end
	end

	// Step waits for memory and for the pending read acknowledge
	assign step = (startup | (phase != IDLE)) & mem_ready & ~read_wait;

	// Destination reads are optional and the write always happens
	assign dst_start = dst_en ? DREAD : (dst_z_en ? DZREAD : DWRITE);
	assign pix_start = src_en ? SREAD : dst_start;

	// Next enabled phase
	always_comb begin
		nxt_phase = IDLE;
		case (phase)
			IDLE: nxt_phase = src_x_en ? SREADX : pix_start;
			SREADX: nxt_phase = src_z_en ? SZREADX : pix_start;
			SZREADX: nxt_phase = pix_start;
			SREAD: nxt_phase = src_z_en ? SZREAD : dst_start;
			SZREAD: nxt_phase = dst_start;
			DREAD: nxt_phase = dst_z_en ? DZREAD : DWRITE;
			DZREAD: nxt_phase = DWRITE;
			// Next pixel skips the X phases
			DWRITE: begin
				if (dst_wr_z) begin
					nxt_phase = DZWRITE;
				end else begin
					nxt_phase = last_pixel ? IDLE : pix_start;
				end
			end
			// Count already dropped at the destination write
			DZWRITE: nxt_phase = last_q ? IDLE : pix_start;
			default: nxt_phase = IDLE;
		endcase
	end

	// Phase only moves on step
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			phase <= IDLE;
		end else if (step) begin
			phase <= nxt_phase;
		end
	end

	// Pixel end choice made at the destination write
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			last_q <= 1'b0;
		end else if (step && (phase == DWRITE)) begin
			last_q <= last_pixel;
		end
	end

	// Phase classes
	assign is_read = (phase == SREADX) | (phase == SZREADX) | (phase == SREAD) |
		(phase == SZREAD) | (phase == DREAD) | (phase == DZREAD);
	assign is_write = (phase == DWRITE) | (phase == DZWRITE);

	// Requests go out with the step
	assign read_req = step & is_read;
	assign write_req = step & is_write & ~no_write;

	// Z address for all Z phases
	assign z_addr = (phase == SZREADX) | (phase == SZREAD) | (phase == DZREAD) |
		(phase == DZWRITE);

	// Final write step returns to idle
	assign loop_end = step & is_write & (nxt_phase == IDLE);

	// Done pulses the cycle after the last step
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			inner_done <= 1'b0;
		end else begin
			inner_done <= loop_end;
		end
	end

	// A step is either a read or a write but never both
	a_req_excl: assert property (@(posedge sys_clk) disable iff (!resetl)
		!(read_req && write_req));

	// Leaving idle needs a step
	a_idle_hold: assert property (@(posedge sys_clk) disable iff (!resetl)
		(phase == IDLE && !step) |=> (phase == IDLE));

endmodule

// ==== hw/inner_counter.sv ====
// Inner loop pixel counter, counts down one per destination write and flags the last pixel
module inner_counter
	import blit_inner_pkg::*;
#(
	parameter int COUNT_W = DEF_COUNT_W
) (
	input  logic               sys_clk,
	input  logic               resetl,
	input  logic               count_ld,
	input  logic [COUNT_W-1:0] count_data,
	input  logic               step,
	input  inner_phase_e       phase,
	output logic [COUNT_W-1:0] count,
	output logic               last_pixel
);

	// One pixel done per write step
	logic pix_dec;

	assign pix_dec = step & (phase == DWRITE);

	// Load wins over a decrement in the same cycle
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			count <= '0;
		end else if (count_ld) begin
			count <= count_data;
		end else if (pix_dec) begin
			count <= count - COUNT_W'(1);
		end
	end

	// Last pixel while one remains
	assign last_pixel = (count == COUNT_W'(1));

	// Loop must end before the count runs out
	a_no_underflow: assert property (@(posedge sys_clk) disable iff (!resetl)
		(pix_dec && !count_ld) |-> (count != '0));

endmodule

// ==== hw/read_tracker.sv ====
// Read tracker, holds the kind of the outstanding read and routes its acknowledge
module read_tracker
	import blit_inner_pkg::*;
(
	input  logic         sys_clk,
	input  logic         resetl,
	input  logic         read_req,
	input  inner_phase_e phase,
	input  logic         read_ack,
	output logic         read_wait,
	output logic         src_data_rd,
	output logic         src_z_rd,
	output logic         dst_data_rd,
	output logic         dst_z_rd
);

	// Kind of the read being issued now
	read_kind_e issue_kind;
	// Kind of the read in flight
	read_kind_e kind_q;

	// Extra source reads deliver into the same source paths
	always_comb begin
		issue_kind = RD_NONE;
		case (phase)
			SREADX, SREAD: issue_kind = RD_SRC;
			SZREADX, SZREAD: issue_kind = RD_SRC_Z;
			DREAD: issue_kind = RD_DST;
			DZREAD: issue_kind = RD_DST_Z;
			default: issue_kind = RD_NONE;
		endcase
	end

	// At most one read outstanding since step waits for the ack
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			kind_q <= RD_NONE;
		end else if (read_req) begin
			kind_q <= issue_kind;
		end else if (read_ack) begin
			kind_q <= RD_NONE;
		end
	end

	assign read_wait = (kind_q != RD_NONE);

	// Data strobes follow the ack in the same cycle
	assign src_data_rd = read_ack & (kind_q == RD_SRC);
	assign src_z_rd = read_ack & (kind_q == RD_SRC_Z);
	assign dst_data_rd = read_ack & (kind_q == RD_DST);
	assign dst_z_rd = read_ack & (kind_q == RD_DST_Z);

	// Memory only answers reads that were asked for
	a_ack_pending: assert property (@(posedge sys_clk) disable iff (!resetl)
		read_ack |-> read_wait);

	// Sequencer holds off new reads until the ack
	a_req_idle: assert property (@(posedge sys_clk) disable iff (!resetl)
		read_req |-> !read_wait);

endmodule

// ==== hw/blit_inner_top.sv ====
// Blitter inner loop top, joins command register, sequencer, pixel counter and read tracker
module blit_inner_top
	import blit_inner_pkg::*;
#(
	parameter int COUNT_W = DEF_COUNT_W
) (
	input  logic               sys_clk,
	input  logic               resetl,
	input  logic               cmd_ld,
	input  logic [CMD_W-1:0]   cmd_data,
	input  logic               count_ld,
	input  logic [COUNT_W-1:0] count_data,
	input  logic               inner_start,
	input  logic               mem_ready,
	input  logic               read_ack,
	input  logic               no_write,
	output inner_phase_e       phase,
	output logic               step,
	output logic               read_req,
	output logic               write_req,
	output logic               z_addr,
	output logic               src_data_rd,
	output logic               src_z_rd,
	output logic               dst_data_rd,
	output logic               dst_z_rd,
	output logic               inner_done,
	output logic [COUNT_W-1:0] count
);

	// Phase enables from the command word
	logic src_en;
	logic src_z_en;
	logic src_x_en;
	logic dst_en;
	logic dst_z_en;
	logic dst_wr_z;

	// Loop end and read back-pressure
	logic last_pixel;
	logic read_wait;

	inner_cmd_reg inner_cmd_reg_inst (
		.sys_clk  (sys_clk),
		.resetl   (resetl),
		.cmd_ld   (cmd_ld),
		.cmd_data (cmd_data),
		.src_en   (src_en),
		.src_z_en (src_z_en),
		.src_x_en (src_x_en),
		.dst_en   (dst_en),
		.dst_z_en (dst_z_en),
		.dst_wr_z (dst_wr_z)
	);

	inner_sequencer inner_sequencer_inst (
		.sys_clk     (sys_clk),
		.resetl      (resetl),
		.inner_start (inner_start),
		.mem_ready   (mem_ready),
		.no_write    (no_write),
		.read_wait   (read_wait),
		.last_pixel  (last_pixel),
		.src_en      (src_en),
		.src_z_en    (src_z_en),
		.src_x_en    (src_x_en),
		.dst_en      (dst_en),
		.dst_z_en    (dst_z_en),
		.dst_wr_z    (dst_wr_z),
		.phase       (phase),
		.step        (step),
		.read_req    (read_req),
		.write_req   (write_req),
		.z_addr      (z_addr),
		.inner_done  (inner_done)
	);

	// Count width comes from the top
	inner_counter #(
		.COUNT_W (COUNT_W)
	) inner_counter_inst (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.count_ld   (count_ld),
		.count_data (count_data),
		.step       (step),
		.phase      (phase),
		.count      (count),
		.last_pixel (last_pixel)
	);

	read_tracker read_tracker_inst (
		.sys_clk     (sys_clk),
		.resetl      (resetl),
		.read_req    (read_req),
		.phase       (phase),
		.read_ack    (read_ack),
		.read_wait   (read_wait),
		.src_data_rd (src_data_rd),
		.src_z_rd    (src_z_rd),
		.dst_data_rd (dst_data_rd),
		.dst_z_rd    (dst_z_rd)
	);

endmodule

// ==== tb/inner_checks.svh ====
// Inner loop testbench helpers with random bit source, reference phase model and compare tasks
`ifndef INNER_CHECKS_SVH
`define INNER_CHECKS_SVH

// Fibonacci LFSR over 16 bits with taps 16 14 13 11
// One shift per bit taken
function automatic logic rand_bit();
	logic fb;
	fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
	lfsr_q = {lfsr_q[14:0], fb};
	return fb;
endfunction

// Several random bits with the MSB first
function automatic int rand_bits(int n);
	int v;
	v = 0;
	for (int i = 0; i < n; i++) begin
		v = (v << 1) | int'(rand_bit());
	end
	return v;
endfunction

// Whether a phase takes part in a pixel for command c
function automatic logic phase_on(inner_phase_e p, logic [CMD_W-1:0] c);
	case (p)
		SREADX: return c[CMD_SRC_X_EN];
		SZREADX: return c[CMD_SRC_X_EN] & c[CMD_SRC_Z_EN];
		SREAD: return c[CMD_SRC_EN];
		// Source Z only rides along with the source read
		SZREAD: return c[CMD_SRC_EN] & c[CMD_SRC_Z_EN];
		DREAD: return c[CMD_DST_EN];
		DZREAD: return c[CMD_DST_Z_EN];
		DZWRITE: return c[CMD_DST_WR_Z];
		default: return 1'b1;
	endcase
endfunction

// Walk forward through the phase list to the next one that is on
// End of a pixel wraps to SREAD unless the counter says last pixel
function automatic inner_phase_e model_next(inner_phase_e cur, logic [CMD_W-1:0] c, int left);
	inner_phase_e p;
	logic found;
	p = cur;
	found = 1'b0;
	while (!found) begin
		if (p == DZWRITE || (p == DWRITE && !c[CMD_DST_WR_Z])) begin
			// The Z write sees the count already dropped for its pixel
			if ((p == DWRITE && left == 1) || (p == DZWRITE && left == 0)) begin
				p = IDLE;
				found = 1'b1;
			end else begin
				// Increment below lands on SREAD and skips the X phases
				p = SZREADX;
			end
		end
		if (!found) begin
			p = inner_phase_e'(p + 4'd1);
			found = phase_on(p, c);
		end
	end
	return p;
endfunction

// Read kind that a phase leaves outstanding
function automatic read_kind_e kind_of(inner_phase_e p);
	case (p)
		SREADX, SREAD: return RD_SRC;
		SZREADX, SZREAD: return RD_SRC_Z;
		DREAD: return RD_DST;
		DZREAD: return RD_DST_Z;
		default: return RD_NONE;
	endcase
endfunction

task automatic check_phase(string name, inner_phase_e got, inner_phase_e exp);
	if (got !== exp) begin
		$display("[FAIL] %s got %h expected %h", name, got, exp);
		abort_run();
	end
endtask

task automatic check_bit(string name, logic got, logic exp);
	if (got !== exp) begin
		$display("[FAIL] %s got %h expected %h", name, got, exp);
		abort_run();
	end
endtask

task automatic check_count(string name, logic [COUNT_W-1:0] got, logic [COUNT_W-1:0] exp);
	if (got !== exp) begin
		$display("[FAIL] %s got %h expected %h", name, got, exp);
		abort_run();
	end
endtask

`endif

// ==== tb/tb_blit_inner.sv ====
// Inner loop testbench that checks random commands and memory timing against a phase model
module tb_blit_inner
	import blit_inner_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int COUNT_W = DEF_COUNT_W;
	localparam int RUNS = 40;
	// Longest loop is 5 pixels of 8 phases with gaps and slow acks
	localparam int LOOP_LIMIT = 500;

	logic               sys_clk;
	logic               resetl;
	logic               cmd_ld;
	logic [CMD_W-1:0]   cmd_data;
	logic               count_ld;
	logic [COUNT_W-1:0] count_data;
	logic               inner_start;
	logic               mem_ready;
	logic               read_ack;
	logic               no_write;
	inner_phase_e       phase;
	logic               step;
	logic               read_req;
	logic               write_req;
	logic               z_addr;
	logic               src_data_rd;
	logic               src_z_rd;
	logic               dst_data_rd;
	logic               dst_z_rd;
	logic               inner_done;
	logic [COUNT_W-1:0] count;

	// Random source state
	logic [15:0] lfsr_q;

	// Reference model state as it stands in the current cycle
	logic [CMD_W-1:0]   exp_cmd;
	logic [COUNT_W-1:0] exp_count;
	inner_phase_e       exp_phase;
	read_kind_e         exp_kind;
	logic               exp_stup;
	logic               exp_done;
	// Cycles left before the memory answers a read
	int                 ack_delay;
	logic               done_seen;
	// Destination write steps seen in the current loop
	int                 dwrites;

	task automatic abort_run();
		$display("test failed");
		$fatal(1);
	endtask

	`include "inner_checks.svh"

	blit_inner_top #(
		.COUNT_W (COUNT_W)
	) blit_inner_top_inst (
		.sys_clk     (sys_clk),
		.resetl      (resetl),
		.cmd_ld      (cmd_ld),
		.cmd_data    (cmd_data),
		.count_ld    (count_ld),
		.count_data  (count_data),
		.inner_start (inner_start),
		.mem_ready   (mem_ready),
		.read_ack    (read_ack),
		.no_write    (no_write),
		.phase       (phase),
		.step        (step),
		.read_req    (read_req),
		.write_req   (write_req),
		.z_addr      (z_addr),
		.src_data_rd (src_data_rd),
		.src_z_rd    (src_z_rd),
		.dst_data_rd (dst_data_rd),
		.dst_z_rd    (dst_z_rd),
		.inner_done  (inner_done),
		.count       (count)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// Falling edge drive of the random memory timing and start pulse
	task automatic drive_cycle(logic start);
		@(negedge sys_clk);
		cmd_ld = 1'b0;
		count_ld = 1'b0;
		inner_start = start;
		mem_ready = (rand_bits(2) != 0);
		no_write = (rand_bits(3) == 0);
		read_ack = 1'b0;
		// Acks only while a read is outstanding
		if (exp_kind != RD_NONE) begin
			if (ack_delay == 0) begin
				read_ack = 1'b1;
			end else begin
				ack_delay = ack_delay - 1;
			end
		end
	endtask

	// Compare settled outputs and then advance the model past the coming edge
	task automatic check_cycle();
		logic exp_step;
		logic rd_ph;
		logic wr_ph;
		inner_phase_e nxt;
		#2;
		check_phase("phase", phase, exp_phase);
		check_count("count", count, exp_count);
		check_bit("inner_done", inner_done, exp_done);
		rd_ph = (kind_of(exp_phase) != RD_NONE);
		wr_ph = (exp_phase == DWRITE) || (exp_phase == DZWRITE);
		// Step needs a start or a running loop, ready memory and no open read
		exp_step = (inner_start | exp_stup | (exp_phase != IDLE)) & mem_ready &
			(exp_kind == RD_NONE);
		check_bit("step", step, exp_step);
		check_bit("read_req", read_req, exp_step & rd_ph);
		check_bit("write_req", write_req, exp_step & wr_ph & ~no_write);
		check_bit("z_addr", z_addr, exp_phase inside {SZREADX, SZREAD, DZREAD, DZWRITE});
		check_bit("src_data_rd", src_data_rd, read_ack & (exp_kind == RD_SRC));
		check_bit("src_z_rd", src_z_rd, read_ack & (exp_kind == RD_SRC_Z));
		check_bit("dst_data_rd", dst_data_rd, read_ack & (exp_kind == RD_DST));
		check_bit("dst_z_rd", dst_z_rd, read_ack & (exp_kind == RD_DST_Z));
		if (inner_done) begin
			done_seen = 1'b1;
		end
		nxt = model_next(exp_phase, exp_cmd, int'(exp_count));
		exp_done = exp_step & (nxt == IDLE);
		exp_stup = (exp_stup | (inner_start & (exp_phase == IDLE))) & ~exp_step;
		if (exp_step & rd_ph) begin
			exp_kind = kind_of(exp_phase);
			ack_delay = rand_bits(2);
		end else if (read_ack) begin
			exp_kind = RD_NONE;
		end
		if (count_ld) begin
			exp_count = count_data;
		end else if (exp_step & (exp_phase == DWRITE)) begin
			exp_count = exp_count - COUNT_W'(1);
		end
		if (exp_step & (exp_phase == DWRITE)) begin
			dwrites++;
		end
		if (cmd_ld) begin
			exp_cmd = cmd_data;
		end
		if (exp_step) begin
			exp_phase = nxt;
		end
	endtask

	// One loop loads command and count, starts and runs to done
	task automatic run_loop(int run);
		logic [CMD_W-1:0] c;
		int n;
		int cycles;
		c = CMD_W'(rand_bits(CMD_W));
		n = rand_bits(3) % 5 + 1;
		@(negedge sys_clk);
		cmd_ld = 1'b1;
		cmd_data = c;
		count_ld = 1'b1;
		count_data = COUNT_W'(n);
		inner_start = 1'b0;
		read_ack = 1'b0;
		check_cycle();
		done_seen = 1'b0;
		dwrites = 0;
		cycles = 0;
		while (!done_seen && cycles < LOOP_LIMIT) begin
			drive_cycle(cycles == 0);
			check_cycle();
			cycles++;
		end
		if (!done_seen) begin
			$display("run %0d: inner loop never signalled done within %0d cycles",
				run, LOOP_LIMIT);
			abort_run();
		end
		// Done follows one destination write per loaded pixel
		check_count("dwrite_steps", COUNT_W'(dwrites), COUNT_W'(n));
	endtask

	initial begin
		resetl = 1'b0;
		cmd_ld = 1'b0;
		cmd_data = '0;
		count_ld = 1'b0;
		count_data = '0;
		inner_start = 1'b0;
		mem_ready = 1'b0;
		read_ack = 1'b0;
		no_write = 1'b0;
		lfsr_q = 16'd85;
		exp_cmd = '0;
		exp_count = '0;
		exp_phase = IDLE;
		exp_kind = RD_NONE;
		exp_stup = 1'b0;
		exp_done = 1'b0;
		ack_delay = 0;
		done_seen = 1'b0;
		dwrites = 0;
		repeat (16) @(posedge sys_clk);
		@(negedge sys_clk);
		resetl = 1'b1;
		// Reset state is idle with no step, requests or done
		check_cycle();
		for (int r = 0; r < RUNS; r++) begin
			run_loop(r);
		end
		$display("test passed");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+tb
common/blit_inner_pkg.sv
inner_seq/inner_cmd_reg.sv
inner_seq/inner_sequencer.sv
hw/inner_counter.sv
hw/read_tracker.sv
hw/blit_inner_top.sv
tb/tb_blit_inner.sv

// ==== Makefile ====
# Verilator build and run of the blitter inner loop testbench

VERILATOR ?= verilator
TOP       ?= tb_blit_inner
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Result comes from the log, not from the simulator exit code
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
